/* hdl/backendPkg.sv */
package backendPkg;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int DMEM_WORDS  = 64;
    localparam int DMEM_ADDR_W = $clog2(DMEM_WORDS);

    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluXor = 3'd4,
        aluSlt = 3'd5, // signed compare
        aluSll = 3'd6,
        aluSrl = 3'd7
    } aluOp_e;

    typedef enum logic [1:0] {
        resAlu     = 2'd0,
        resMem     = 2'd1,
        resPcPlus4 = 2'd2 // link value for jal/jalr
    } resultSrc_e;

    // operand source seen by execute
    typedef enum logic [1:0] {
        fwdRegs    = 2'd0,
        fwdFromWb  = 2'd1,
        fwdFromMem = 2'd2
    } fwdSel_e;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        aluOp_e                aluOp;
        logic                  aluSrcImm;
        logic                  regWrite;
        logic                  memWrite;
        resultSrc_e            resultSrc;
        logic                  branch;
        logic                  branchNe; // invert zero flag
        logic                  jump;
        logic                  jalr;
    } decodedInstr_t;

    typedef struct packed {
        decodedInstr_t   instr;
        logic [XLEN-1:0] rd1;
        logic [XLEN-1:0] rd2;
    } execPayload_t;

    typedef struct packed {
        logic [XLEN-1:0]       aluResult;
        logic [XLEN-1:0]       writeData;
        logic [XLEN-1:0]       pcPlus4;
        logic [REG_ADDR_W-1:0] rd;
        logic                  regWrite;
        logic                  memWrite;
        resultSrc_e            resultSrc;
    } memPayload_t;

    typedef struct packed {
        logic [XLEN-1:0]       aluResult;
        logic [XLEN-1:0]       readData;
        logic [XLEN-1:0]       pcPlus4;
        logic [REG_ADDR_W-1:0] rd;
        logic                  regWrite;
        resultSrc_e            resultSrc;
    } wbPayload_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } writeback_t;

endpackage

/* hdl/alu.sv */
`timescale 1ns/100ps

module alu (
    input  backendPkg::aluOp_e          op_i,
    input  logic [backendPkg::XLEN-1:0] a_i,
    input  logic [backendPkg::XLEN-1:0] b_i,
    output logic [backendPkg::XLEN-1:0] result_o,
    output logic                        zero_o
);
    import backendPkg::*;

    logic [4:0]      shamt;
    logic [XLEN-1:0] result;

    assign shamt = b_i[4:0]; // rv32 shift amount

    always_comb begin
        result = '0;
        case (op_i)
            aluAdd: begin
                result = a_i + b_i;
            end
            aluSub: begin
                result = a_i - b_i;
            end
            aluAnd: begin
                result = a_i & b_i;
            end
            aluOr: begin
                result = a_i | b_i;
            end
            aluXor: begin
                result = a_i ^ b_i;
            end
            aluSlt: begin
                result = {{(XLEN-1){1'b0}}, ($signed(a_i) < $signed(b_i))};
            end
            aluSll: begin
                result = a_i << shamt;
            end
            aluSrl: begin
                result = a_i >> shamt; // logical
            end
            default: ;
        endcase
    end

    assign result_o = result;
    assign zero_o   = (result == '0);

endmodule

/* hdl/regFile.sv */
`timescale 1ns/100ps

module regFile (
    input  logic                              clk,
    input  logic                              arstN_i,
    input  logic [backendPkg::REG_ADDR_W-1:0] rs1_i,
    input  logic [backendPkg::REG_ADDR_W-1:0] rs2_i,
    input  logic [backendPkg::REG_ADDR_W-1:0] rd_i,
    input  logic                              we_i,
    input  logic [backendPkg::XLEN-1:0]       wd_i,
    output logic [backendPkg::XLEN-1:0]       rd1_o,
    output logic [backendPkg::XLEN-1:0]       rd2_o,
    output logic [backendPkg::XLEN-1:0]       a0_o
);
    import backendPkg::*;

    logic [XLEN-1:0] regs [1:31]; // x0 has no storage

    function automatic logic [XLEN-1:0] readPort(logic [REG_ADDR_W-1:0] addr);
        if (addr == '0)
            readPort = '0;
        else if (we_i && (rd_i == addr))
            readPort = wd_i; // write-through
        else
            readPort = regs[addr];
    endfunction

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (we_i && (rd_i != '0)) begin
            regs[rd_i] <= wd_i;
        end
    end

    always_comb begin
        rd1_o = readPort(rs1_i);
        rd2_o = readPort(rs2_i);
    end

    assign a0_o = regs[10];

endmodule

/* hdl/forwardUnit.sv */
`timescale 1ns/100ps

module forwardUnit (
    input  logic [backendPkg::REG_ADDR_W-1:0] rs1E_i,
    input  logic [backendPkg::REG_ADDR_W-1:0] rs2E_i,
    input  logic [backendPkg::REG_ADDR_W-1:0] memRd_i,
    input  logic                              memWrites_i, // M valid and regWrite
    input  logic [backendPkg::REG_ADDR_W-1:0] wbRd_i,
    input  logic                              wbWrites_i,  // W valid and regWrite
    output backendPkg::fwdSel_e               fwdA_o,
    output backendPkg::fwdSel_e               fwdB_o
);
    import backendPkg::*;

    logic memLive;
    logic wbLive;

    assign memLive = memWrites_i && (memRd_i != '0);
    assign wbLive  = wbWrites_i && (wbRd_i != '0);

    // younger producer in M wins over W
    function automatic fwdSel_e pickSource(logic [REG_ADDR_W-1:0] rs);
        if (memLive && (memRd_i == rs))
            pickSource = fwdFromMem;
        else if (wbLive && (wbRd_i == rs))
            pickSource = fwdFromWb;
        else
            pickSource = fwdRegs;
    endfunction

    always_comb begin
        fwdA_o = pickSource(rs1E_i);
        fwdB_o = pickSource(rs2E_i);
    end

endmodule

/* hdl/executeStage.sv */
`timescale 1ns/100ps

module executeStage (
    input  logic                        valid_i,
    input  backendPkg::execPayload_t    payload_i,
    input  backendPkg::fwdSel_e         fwdA_i,
    input  backendPkg::fwdSel_e         fwdB_i,
    input  logic [backendPkg::XLEN-1:0] memFwd_i, // aluResult in M
    input  logic [backendPkg::XLEN-1:0] wbFwd_i,  // final result in W
    output backendPkg::memPayload_t     payload_o,
    output backendPkg::redirect_t       redirect_o
);
    import backendPkg::*;

    decodedInstr_t   instr;
    logic [XLEN-1:0] srcA;
    logic [XLEN-1:0] fwdB;
    logic [XLEN-1:0] srcB;
    logic [XLEN-1:0] aluResult;
    logic            zero;
    logic [XLEN-1:0] targetBase;
    logic [XLEN-1:0] targetSum;
    logic            condTrue;
    logic            taken;

    function automatic logic [XLEN-1:0] pickOperand(fwdSel_e sel, logic [XLEN-1:0] regVal);
        case (sel)
            fwdFromMem: pickOperand = memFwd_i;
            fwdFromWb:  pickOperand = wbFwd_i;
            default:    pickOperand = regVal;
        endcase
    endfunction

    assign instr = payload_i.instr;

    always_comb begin
        srcA = pickOperand(fwdA_i, payload_i.rd1);
        fwdB = pickOperand(fwdB_i, payload_i.rd2);
    end

    assign srcB = instr.aluSrcImm ? instr.imm : fwdB;

    alu aluInst (
        .op_i     (instr.aluOp),
        .a_i      (srcA),
        .b_i      (srcB),
        .result_o (aluResult),
        .zero_o   (zero)
    );

    // jalr bases on rs1, everything else on pc
    assign targetBase = instr.jalr ? srcA : instr.pc;
    assign targetSum  = targetBase + instr.imm;

    assign condTrue = zero ^ instr.branchNe; // bne flips the sense
    assign taken    = valid_i && ((instr.branch && condTrue) || instr.jump);

    assign redirect_o.valid  = taken;
    assign redirect_o.target = {targetSum[XLEN-1:1], 1'b0};

    always_comb begin
        payload_o.aluResult = aluResult;
        payload_o.writeData = fwdB; // store data, forwarded rs2
        payload_o.pcPlus4   = instr.pc + XLEN'(4);
        payload_o.rd        = instr.rd;
        payload_o.regWrite  = instr.regWrite;
        payload_o.memWrite  = instr.memWrite;
        payload_o.resultSrc = instr.resultSrc;
    end

endmodule

/* hdl/dataMem.sv */
`timescale 1ns/100ps

module dataMem (
    input  logic                               clk,
    input  logic                               arstN_i,
    input  logic                               we_i,
    input  logic [backendPkg::DMEM_ADDR_W-1:0] addr_i, // word index
    input  logic [backendPkg::XLEN-1:0]        wd_i,
    output logic [backendPkg::XLEN-1:0]        rdata_o
);
    import backendPkg::*;

    logic [XLEN-1:0] mem [DMEM_WORDS];

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            for (int i = 0; i < DMEM_WORDS; i++)
                mem[i] <= '0;
        end else if (we_i) begin
            mem[addr_i] <= wd_i;
        end
    end

    // async read so a load is ready within the M cycle
    assign rdata_o = mem[addr_i];

endmodule

/* hdl/pipeReg.sv */
`timescale 1ns/100ps

module pipeReg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arstN_i,
    input  logic     bubble_i, // squash what is being loaded
    input  logic     valid_i,
    input  payload_t payload_i,
    output logic     valid_o,
    output payload_t payload_o
);

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i)
            valid_o <= 1'b0;
        else
            valid_o <= valid_i && !bubble_i;
    end

    // no stall, payload follows every edge
    always_ff @(posedge clk) begin
        payload_o <= payload_i;
    end

endmodule

/* hdl/backendTop.sv */
`timescale 1ns/100ps

module backendTop (
    input  logic                        clk,
    input  logic                        arstN_i,
    input  logic                        validD_i,
    input  backendPkg::decodedInstr_t   instrD_i,
    output backendPkg::redirect_t       redirect_o,
    output backendPkg::writeback_t      writeback_o,
    output logic [backendPkg::XLEN-1:0] a0_o
);
    import backendPkg::*;

    logic [XLEN-1:0] rd1D;
    logic [XLEN-1:0] rd2D;
    execPayload_t    payloadD;

    logic            validE;
    execPayload_t    payloadE;
    fwdSel_e         fwdA;
    fwdSel_e         fwdB;
    memPayload_t     memPayloadE;
    redirect_t       redirectE;

    logic            validM;
    memPayload_t     payloadM;
    logic [XLEN-1:0] readDataM;
    wbPayload_t      wbPayloadM;

    logic            validW;
    wbPayload_t      payloadW;
    logic [XLEN-1:0] resultW;
    logic            regWriteW;

    regFile regs (
        .clk     (clk),
        .arstN_i (arstN_i),
        .rs1_i   (instrD_i.rs1),
        .rs2_i   (instrD_i.rs2),
        .rd_i    (payloadW.rd),
        .we_i    (regWriteW),
        .wd_i    (resultW),
        .rd1_o   (rd1D),
        .rd2_o   (rd2D),
        .a0_o    (a0_o)
    );

    assign payloadD = '{instr: instrD_i, rd1: rd1D, rd2: rd2D};

    // a taken redirect kills the shadow slot
    pipeReg #(.payload_t(execPayload_t)) deReg (
        .clk       (clk),
        .arstN_i   (arstN_i),
        .bubble_i  (redirectE.valid),
        .valid_i   (validD_i),
        .payload_i (payloadD),
        .valid_o   (validE),
        .payload_o (payloadE)
    );

    forwardUnit fwd (
        .rs1E_i      (payloadE.instr.rs1),
        .rs2E_i      (payloadE.instr.rs2),
        .memRd_i     (payloadM.rd),
        .memWrites_i (validM && payloadM.regWrite),
        .wbRd_i      (payloadW.rd),
        .wbWrites_i  (validW && payloadW.regWrite),
        .fwdA_o      (fwdA),
        .fwdB_o      (fwdB)
    );

    executeStage exec (
        .valid_i    (validE),
        .payload_i  (payloadE),
        .fwdA_i     (fwdA),
        .fwdB_i     (fwdB),
        .memFwd_i   (payloadM.aluResult),
        .wbFwd_i    (resultW),
        .payload_o  (memPayloadE),
        .redirect_o (redirectE)
    );

    pipeReg #(.payload_t(memPayload_t)) emReg (
        .clk       (clk),
        .arstN_i   (arstN_i),
        .bubble_i  (1'b0),
        .valid_i   (validE),
        .payload_i (memPayloadE),
        .valid_o   (validM),
        .payload_o (payloadM)
    );

    dataMem dmem (
        .clk     (clk),
        .arstN_i (arstN_i),
        .we_i    (validM && payloadM.memWrite),
        .addr_i  (payloadM.aluResult[DMEM_ADDR_W+1:2]), // byte address to word
        .wd_i    (payloadM.writeData),
        .rdata_o (readDataM)
    );

    assign wbPayloadM = '{aluResult: payloadM.aluResult, readData: readDataM,
                          pcPlus4: payloadM.pcPlus4, rd: payloadM.rd,
                          regWrite: payloadM.regWrite, resultSrc: payloadM.resultSrc};

    pipeReg #(.payload_t(wbPayload_t)) mwReg (
        .clk       (clk),
        .arstN_i   (arstN_i),
        .bubble_i  (1'b0),
        .valid_i   (validM),
        .payload_i (wbPayloadM),
        .valid_o   (validW),
        .payload_o (payloadW)
    );

    always_comb begin
        case (payloadW.resultSrc)
            resMem:     resultW = payloadW.readData;
            resPcPlus4: resultW = payloadW.pcPlus4;
            default:    resultW = payloadW.aluResult;
        endcase
    end

    assign regWriteW = validW && payloadW.regWrite && (payloadW.rd != '0);

    assign redirect_o = redirectE;

    assign writeback_o.valid = regWriteW;
    assign writeback_o.rd    = payloadW.rd;
    assign writeback_o.data  = resultW;

endmodule

/* tb/backendAssert_assert.sv */
`timescale 1ns/100ps

module backendAssert (
    input logic                              clk,
    input logic                              arstN_i,
    input logic                              validD_i,
    input logic [backendPkg::REG_ADDR_W-1:0] rdD_i,
    input backendPkg::redirect_t             redirect_i,
    input backendPkg::writeback_t            writeback_i
);

    // first edge out of reset sees an empty W stage
    quietAfterReset: assert property (@(posedge clk) $rose(arstN_i) |-> !writeback_i.valid)
        else $error("writeback in the first cycle after reset");

    // a writeback belongs to the strobe three cycles back
    noWriteX0: assert property (@(posedge clk) disable iff (!arstN_i)
        writeback_i.valid |-> (writeback_i.rd != '0) && $past(validD_i, 3)
                              && (writeback_i.rd == $past(rdD_i, 3)))
        else $error("writeback aimed at x0 or at the wrong register");

    redirectFollowsStrobe: assert property (@(posedge clk) disable iff (!arstN_i)
        redirect_i.valid |-> $past(validD_i))
        else $error("redirect without a strobe in the previous cycle");

endmodule

bind backendTop backendAssert invariants (
    .clk         (clk),
    .arstN_i     (arstN_i),
    .validD_i    (validD_i),
    .rdD_i       (instrD_i.rd),
    .redirect_i  (redirect_o),
    .writeback_i (writeback_o)
);

/* tb/backendTb.sv */
`timescale 1ns/100ps

module backendTb;
    import backendPkg::*;

    typedef struct packed {
        logic          valid;
        decodedInstr_t instr;
        writeback_t    expWb;
        redirect_t     expRedir;
    } slot_t;

    logic          clk = 1'b0;
    logic          arstN_i;
    logic          validD_i;
    decodedInstr_t instrD_i;
    redirect_t     redirect_o;
    writeback_t    writeback_o;
    logic [XLEN-1:0] a0_o;

    slot_t rows[$];
    int    cycleCount = 0;
    int    cycleLimit = 20;

    backendTop UUT (
        .clk         (clk),
        .arstN_i     (arstN_i),
        .validD_i    (validD_i),
        .instrD_i    (instrD_i),
        .redirect_o  (redirect_o),
        .writeback_o (writeback_o),
        .a0_o        (a0_o)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit)
            stopRun($sformatf("timeout: run did not finish within %0d cycles", cycleLimit));
    end

    function automatic decodedInstr_t immOp(aluOp_e op, logic [REG_ADDR_W-1:0] rd,
                                            logic [REG_ADDR_W-1:0] rs1, logic [XLEN-1:0] imm);
        decodedInstr_t d;
        d = '0;
        d.aluOp     = op;
        d.rd        = rd;
        d.rs1       = rs1;
        d.imm       = imm;
        d.aluSrcImm = 1'b1;
        d.regWrite  = 1'b1;
        return d;
    endfunction

    function automatic decodedInstr_t regOp(aluOp_e op, logic [REG_ADDR_W-1:0] rd,
                                            logic [REG_ADDR_W-1:0] rs1,
                                            logic [REG_ADDR_W-1:0] rs2);
        decodedInstr_t d;
        d = immOp(op, rd, rs1, '0);
        d.rs2       = rs2;
        d.aluSrcImm = 1'b0;
        return d;
    endfunction

    function automatic decodedInstr_t storeOp(logic [REG_ADDR_W-1:0] rs1,
                                              logic [REG_ADDR_W-1:0] rs2, logic [XLEN-1:0] imm);
        decodedInstr_t d;
        d = immOp(aluAdd, '0, rs1, imm);
        d.rs2      = rs2; // store data
        d.regWrite = 1'b0;
        d.memWrite = 1'b1;
        return d;
    endfunction

    function automatic decodedInstr_t loadOp(logic [REG_ADDR_W-1:0] rd,
                                             logic [REG_ADDR_W-1:0] rs1, logic [XLEN-1:0] imm);
        decodedInstr_t d;
        d = immOp(aluAdd, rd, rs1, imm);
        d.resultSrc = resMem; // word read from memory
        return d;
    endfunction

    function automatic decodedInstr_t branchOp(logic ne, logic [REG_ADDR_W-1:0] rs1,
                                               logic [REG_ADDR_W-1:0] rs2, logic [XLEN-1:0] imm);
        decodedInstr_t d;
        d = regOp(aluSub, '0, rs1, rs2);
        d.imm      = imm;
        d.regWrite = 1'b0;
        d.branch   = 1'b1;
        d.branchNe = ne;
        return d;
    endfunction

    function automatic decodedInstr_t jumpOp(logic isJalr, logic [REG_ADDR_W-1:0] rd,
                                             logic [REG_ADDR_W-1:0] rs1, logic [XLEN-1:0] imm);
        decodedInstr_t d;
        d = immOp(aluAdd, rd, rs1, imm);
        d.jump      = 1'b1;
        d.jalr      = isJalr;
        d.resultSrc = resPcPlus4; // link value
        return d;
    endfunction

    function automatic writeback_t wbTo(logic [REG_ADDR_W-1:0] rd, logic [XLEN-1:0] data);
        return '{valid: 1'b1, rd: rd, data: data};
    endfunction

    function automatic redirect_t redirectTo(logic [XLEN-1:0] target);
        return '{valid: 1'b1, target: target};
    endfunction

    // pc of the row about to be appended
    function automatic logic [XLEN-1:0] slotPc();
        return 32'h100 + XLEN'(4 * rows.size());
    endfunction

    task automatic addRow(logic valid, decodedInstr_t d, writeback_t wb, redirect_t rdr);
        slot_t s;
        s.valid    = valid;
        s.instr    = d;
        s.instr.pc = slotPc();
        s.expWb    = wb;
        s.expRedir = rdr;
        rows.push_back(s);
    endtask

    task automatic stopRun(string line);
        $display("%s", line);
        $display("TEST FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic checkWriteback(writeback_t got, writeback_t exp, int slot);
        if (got.valid !== exp.valid ||
            (exp.valid && (got.rd !== exp.rd || got.data !== exp.data)))
            stopRun($sformatf(
                "[FAIL] %0t writeback for slot %0d: got %0b x%0d %h, expected %0b x%0d %h",
                $time, slot, got.valid, got.rd, got.data, exp.valid, exp.rd, exp.data));
    endtask

    task automatic checkRedirect(redirect_t got, redirect_t exp, int slot);
        if (got.valid !== exp.valid || (exp.valid && got.target !== exp.target))
            stopRun($sformatf("[FAIL] %0t redirect for slot %0d: got %0b %h, expected %0b %h",
                              $time, slot, got.valid, got.target, exp.valid, exp.target));
    endtask

    task automatic checkWord(logic [XLEN-1:0] got, logic [XLEN-1:0] exp, string what);
        if (got !== exp)
            stopRun($sformatf("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp));
    endtask

    initial begin
        writeback_t expWb;
        redirect_t  expRedir;
        arstN_i  = 1'b0;
        validD_i = 1'b0;
        instrD_i = '0;

        addRow(1'b0, '0, '0, '0); // quiet after reset
        addRow(1'b1, immOp(aluAdd, 5'd1, 5'd0, 32'd100), wbTo(5'd1, 32'd100), '0);
        addRow(1'b1, immOp(aluSub, 5'd2, 5'd0, 32'd7), wbTo(5'd2, 32'hFFFF_FFF9), '0);
        addRow(1'b1, immOp(aluAnd, 5'd3, 5'd0, 32'hFF), wbTo(5'd3, 32'h0), '0);
        addRow(1'b1, immOp(aluOr, 5'd4, 5'd0, 32'h5A5), wbTo(5'd4, 32'h5A5), '0);
        addRow(1'b1, immOp(aluXor, 5'd5, 5'd0, 32'h33), wbTo(5'd5, 32'h33), '0);
        addRow(1'b1, immOp(aluSlt, 5'd6, 5'd0, 32'd5), wbTo(5'd6, 32'd1), '0);
        addRow(1'b1, immOp(aluSll, 5'd7, 5'd0, 32'd3), wbTo(5'd7, 32'h0), '0);
        addRow(1'b1, immOp(aluSrl, 5'd8, 5'd0, 32'd1), wbTo(5'd8, 32'h0), '0);
        addRow(1'b1, immOp(aluAdd, 5'd0, 5'd0, 32'd5), '0, '0); // x0 never written
        // forwarding at distance 1, 2 and 3
        addRow(1'b1, immOp(aluAdd, 5'd12, 5'd0, 32'h10), wbTo(5'd12, 32'h10), '0);
        addRow(1'b1, immOp(aluAdd, 5'd13, 5'd12, 32'h1), wbTo(5'd13, 32'h11), '0);
        addRow(1'b1, regOp(aluAdd, 5'd14, 5'd12, 5'd13), wbTo(5'd14, 32'h21), '0);
        addRow(1'b1, regOp(aluSub, 5'd15, 5'd14, 5'd12), wbTo(5'd15, 32'h11), '0);
        addRow(1'b1, regOp(aluSll, 5'd16, 5'd13, 5'd12), wbTo(5'd16, 32'h0011_0000), '0);
        addRow(1'b1, regOp(aluSlt, 5'd18, 5'd2, 5'd1), wbTo(5'd18, 32'd1), '0); // -7 < 100
        // store then load, one empty slot before the use
        addRow(1'b1, immOp(aluAdd, 5'd20, 5'd0, 32'h40), wbTo(5'd20, 32'h40), '0);
        addRow(1'b1, storeOp(5'd20, 5'd15, 32'd8), '0, '0);
        addRow(1'b1, loadOp(5'd21, 5'd20, 32'd8), wbTo(5'd21, 32'h11), '0);
        addRow(1'b0, '0, '0, '0);
        addRow(1'b1, regOp(aluAdd, 5'd22, 5'd21, 5'd1), wbTo(5'd22, 32'h75), '0);
        // branches, taken and not taken
        addRow(1'b1, branchOp(1'b0, 5'd1, 5'd1, 32'h20), '0, redirectTo(slotPc() + 32'h20));
        addRow(1'b1, immOp(aluAdd, 5'd23, 5'd0, 32'h99), '0, '0); // shadow
        addRow(1'b1, branchOp(1'b1, 5'd1, 5'd2, 32'hFFFF_FFF8), '0,
               redirectTo(slotPc() - 32'd8));
        addRow(1'b1, immOp(aluAdd, 5'd23, 5'd0, 32'h99), '0, '0); // shadow
        addRow(1'b1, branchOp(1'b0, 5'd1, 5'd2, 32'h10), '0, '0);
        addRow(1'b1, branchOp(1'b1, 5'd1, 5'd1, 32'h10), '0, '0);
        // jal and jalr
        addRow(1'b1, jumpOp(1'b0, 5'd25, 5'd0, 32'h40), wbTo(5'd25, slotPc() + 32'd4),
               redirectTo(slotPc() + 32'h40));
        addRow(1'b1, immOp(aluAdd, 5'd26, 5'd0, 32'h55), '0, '0); // shadow
        addRow(1'b1, immOp(aluAdd, 5'd27, 5'd0, 32'h201), wbTo(5'd27, 32'h201), '0);
        addRow(1'b1, jumpOp(1'b1, 5'd28, 5'd27, 32'h10), wbTo(5'd28, slotPc() + 32'd4),
               redirectTo(32'h210)); // low bit cleared
        addRow(1'b1, immOp(aluAdd, 5'd26, 5'd0, 32'h66), '0, '0); // shadow
        addRow(1'b1, immOp(aluAdd, 5'd10, 5'd0, 32'h7AB), wbTo(5'd10, 32'h7AB), '0);
        cycleLimit = rows.size() + 20;

        repeat (3) @(posedge clk);
        #1 arstN_i = 1'b1;

        for (int k = 0; k < rows.size() + 3; k++) begin
            @(posedge clk);
            #1;
            validD_i = 1'b0;
            instrD_i = '0;
            if (k < rows.size()) begin
                validD_i = rows[k].valid;
                instrD_i = rows[k].instr;
            end
            @(negedge clk); // mid cycle, outputs settled
            expRedir = '0;
            expWb    = '0;
            if (k >= 1 && k <= rows.size())
                expRedir = rows[k-1].expRedir;
            if (k >= 3)
                expWb = rows[k-3].expWb;
            checkRedirect(redirect_o, expRedir, k - 1);
            checkWriteback(writeback_o, expWb, k - 3);
        end

        @(posedge clk);
        @(negedge clk);
        checkWord(a0_o, 32'h7AB, "a0 at end of run");
        $display("TEST PASS");
        $finish;
    end

endmodule

/* files.f */
hdl/backendPkg.sv
hdl/alu.sv
hdl/regFile.sv
hdl/forwardUnit.sv
hdl/executeStage.sv
hdl/dataMem.sv
hdl/pipeReg.sv
hdl/backendTop.sv
tb/backendAssert_assert.sv
tb/backendTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= backendTb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only when the testbench printed its pass line
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q '^TEST PASS$$'

clean:
	rm -rf $(OBJ_DIR)
